// File: Makefile
# Verilator build and run for the UART bank testbench
# any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_uart_bank
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** PASSED ***' $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_apb_tasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// one APB transfer, entered and left one time unit after a rising edge
task automatic do_transfer(input logic write, input logic [7:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
   psel    = 1'b1;  // SETUP phase
   penable = 1'b0;
   pwrite  = write;
   paddr   = addr;
   pwdata  = wdata;
   @(posedge clk);
   #1;
   penable = 1'b1;  // ACCESS phase
   #2;
   rdata   = prdata;  // read data is combinational and settled mid-cycle
   err     = pslverr;
   @(posedge clk);
   #1;
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
   assert (got === exp)
      else fail_run($sformatf("Mismatch %s: expected %h, got %h", name, exp, got));
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
   logic [31:0] rdata;
   logic        err;
   do_transfer(1'b1, addr, wdata, rdata, err);
   check_value("pslverr", 32'h0, {31'b0, err});
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
   logic err;
   do_transfer(1'b0, addr, 32'h0, rdata, err);
   check_value("pslverr", 32'h0, {31'b0, err});
endtask

task automatic check_read(input logic [7:0] addr, input logic [31:0] exp, input string name);
   logic [31:0] got;
   read_reg(addr, got);
   check_value(name, exp, got);
endtask

// 13/17/5 xorshift, never returns zero for a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

`endif

// File: bench/tb_uart_bank.sv
module tb_uart_bank;
   import uart_pkg::*;

   localparam int NUM_CH       = 4;
   localparam int CLKS_PER_BIT = 8;
   localparam int NUM_FRAMES   = 11;  // frames sent over the whole sequence
   localparam int TIMEOUT      = NUM_FRAMES * 10 * CLKS_PER_BIT * 8 * 2 + 20000;

   logic              clk;
   logic              reset_b;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [7:0]        paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   logic              irq;
   logic [NUM_CH-1:0] rxd;
   logic [NUM_CH-1:0] txd;

   logic [31:0] rng_state = 32'h31a2;
   logic [31:0] value;
   logic [7:0]  b0;
   logic [7:0]  b1;
   int          nxt;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "stopping at the first error");
   endtask

   `include "tb_apb_tasks.svh"

   uart_bank #(
      .NUM_CH       (NUM_CH),
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) dut0 (
      .clk     (clk),
      .reset_b (reset_b),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irq     (irq),
      .rxd     (rxd),
      .txd     (txd)
   );

   assign rxd = {txd[NUM_CH-2:0], txd[NUM_CH-1]};  // channel i sends to channel i+1

   always #4 clk = ~clk;

   assert property (@(posedge clk) pready == (psel && penable))
      else fail_run($sformatf("Mismatch pready: expected %h, got %h", psel && penable, pready));

   // txd is checked from the second reset cycle, once the flops have been reset
   assert property (@(posedge clk) !reset_b |=> (reset_b || (&txd)))
      else fail_run("txd left the idle level while reset was held");

   function automatic logic [7:0] reg_addr(input int ch, input int off);
      return {4'(ch), 2'(off), 2'b00};
   endfunction

   task automatic next_byte(output logic [7:0] b);
      rng_state = xorshift32(rng_state);
      b = rng_state[7:0];
   endtask

   // poll STATUS until one of the mask bits is set, the watchdog bounds the loop
   task automatic poll_status(input int ch, input logic [31:0] mask, output logic [31:0] st);
      st = 32'h0;
      while ((st & mask) == 32'h0) begin
         read_reg(reg_addr(ch, REG_STATUS), st);
      end
   endtask

   task automatic wait_tx_idle(input int ch);
      logic [31:0] st;
      st = 32'h2;
      while (st[1]) begin
         read_reg(reg_addr(ch, REG_STATUS), st);
      end
   endtask

   task automatic expect_error(input logic write, input logic [7:0] addr, input logic [31:0] wdata);
      logic [31:0] rdata;
      logic        err;
      do_transfer(write, addr, wdata, rdata, err);
      check_value("pslverr", 32'h1, {31'b0, err});
      if (!write) begin
         check_value("prdata", 32'h0, rdata);
      end
   endtask

   initial begin
      #(TIMEOUT);
      fail_run("timeout: the test sequence did not finish in time");
   end

   initial begin
      clk     = 1'b0;
      reset_b = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = 8'h0;
      pwdata  = 32'h0;
      repeat (8) @(posedge clk);
      #1;
      reset_b = 1'b1;

      for (int ch = 0; ch < NUM_CH; ch++) begin  // reset values
         check_read(reg_addr(ch, REG_STATUS), 32'h0, "status");
         check_read(reg_addr(ch, REG_CTRL), 32'h0, "ctrl");
      end
      check_value("irq", 32'h0, {31'b0, irq});

      for (int ch = 0; ch < NUM_CH; ch++) begin  // loopback around the ring
         nxt = (ch + 1) % NUM_CH;
         next_byte(b0);
         write_reg(reg_addr(ch, REG_DATA), {24'h0, b0});
         poll_status(nxt, 32'h1, value);
         check_read(reg_addr(nxt, REG_DATA), {24'h0, b0}, "rx_data");
         check_read(reg_addr(nxt, REG_STATUS), 32'h0, "status");
         wait_tx_idle(ch);
      end

      next_byte(b0);  // a write while busy is dropped
      next_byte(b1);
      if (b1 == b0) begin
         b1 = ~b0;
      end
      write_reg(reg_addr(0, REG_DATA), {24'h0, b0});
      check_read(reg_addr(0, REG_STATUS), 32'h2, "status");
      write_reg(reg_addr(0, REG_DATA), {24'h0, b1});
      poll_status(1, 32'h1, value);
      check_read(reg_addr(1, REG_DATA), {24'h0, b0}, "rx_data");
      wait_tx_idle(0);
      repeat (12 * CLKS_PER_BIT) @(posedge clk);
      #1;
      check_read(reg_addr(1, REG_STATUS), 32'h0, "status");
      next_byte(b1);
      write_reg(reg_addr(0, REG_DATA), {24'h0, b1});
      poll_status(1, 32'h1, value);
      check_read(reg_addr(1, REG_DATA), {24'h0, b1}, "rx_data");
      wait_tx_idle(0);

      next_byte(b0);  // overrun keeps the first byte
      next_byte(b1);
      if (b1 == b0) begin
         b1 = ~b0;
      end
      write_reg(reg_addr(1, REG_DATA), {24'h0, b0});
      poll_status(2, 32'h1, value);
      wait_tx_idle(1);
      write_reg(reg_addr(1, REG_DATA), {24'h0, b1});
      poll_status(2, 32'h4, value);
      check_value("status", 32'h5, value);
      check_read(reg_addr(2, REG_DATA), {24'h0, b0}, "rx_data");
      check_read(reg_addr(2, REG_STATUS), 32'h0, "status");
      wait_tx_idle(1);

      write_reg(reg_addr(3, REG_CTRL), 32'h1);  // interrupt on channel 3
      check_read(reg_addr(3, REG_CTRL), 32'h1, "ctrl");
      check_value("irq", 32'h0, {31'b0, irq});
      next_byte(b0);
      write_reg(reg_addr(2, REG_DATA), {24'h0, b0});
      while (irq !== 1'b1) begin
         @(posedge clk);
         #1;
      end
      check_read(reg_addr(3, REG_STATUS), 32'h9, "status");
      check_read(reg_addr(3, REG_DATA), {24'h0, b0}, "rx_data");
      @(posedge clk);
      #1;
      check_value("irq", 32'h0, {31'b0, irq});
      write_reg(reg_addr(3, REG_CTRL), 32'h0);
      wait_tx_idle(2);
      next_byte(b1);
      write_reg(reg_addr(2, REG_DATA), {24'h0, b1});
      poll_status(3, 32'h1, value);
      check_value("status", 32'h1, value);
      repeat (2) @(posedge clk);
      #1;
      check_value("irq", 32'h0, {31'b0, irq});
      check_read(reg_addr(3, REG_DATA), {24'h0, b1}, "rx_data");
      wait_tx_idle(2);

      write_reg(reg_addr(1, REG_CTRL), 32'h1);  // give channel 1 state a bad access could disturb
      next_byte(b0);
      write_reg(reg_addr(0, REG_DATA), {24'h0, b0});
      poll_status(1, 32'h1, value);
      wait_tx_idle(0);
      expect_error(1'b1, reg_addr(4, REG_DATA), 32'h55);
      expect_error(1'b0, reg_addr(4, REG_STATUS), 32'h0);
      expect_error(1'b1, reg_addr(1, 3), 32'h0);
      expect_error(1'b0, reg_addr(1, 3), 32'h0);
      for (int ch = 0; ch < NUM_CH; ch++) begin
         check_read(reg_addr(ch, REG_STATUS), (ch == 1) ? 32'h9 : 32'h0, "status");
      end
      check_read(reg_addr(1, REG_DATA), {24'h0, b0}, "rx_data");

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: hdl/apb_decode.sv
module apb_decode #(
   parameter int NUM_CH = 4
) (
   input  logic                             clk,
   input  logic                             reset_b,
   input  logic                             psel,
   input  logic                             penable,
   input  logic                             pwrite,
   input  logic [7:0]                       paddr,
   input  logic [31:0]                      pwdata,
   output logic                             pready,
   output logic                             pslverr,
   output uart_pkg::ch_cmd_t [NUM_CH-1:0]   cmd,
   output uart_pkg::rd_sel_t                rd_sel
);
   import uart_pkg::*;

   // never decode more channels than the address field can reach
   localparam int CH_LIMIT = (NUM_CH < MAX_CH) ? NUM_CH : MAX_CH;

   logic [3:0] ch_idx;
   logic [1:0] reg_off;
   reg_sel_e   reg_sel;
   logic       ch_ok;
   logic       reg_ok;
   logic       addr_ok;
   logic       access;
   logic       setup_q;
   logic       strobe;

   assign ch_idx  = paddr[7:4];
   assign reg_off = paddr[3:2];
   assign reg_sel = reg_sel_e'(reg_off);

   assign ch_ok   = int'(ch_idx) < CH_LIMIT;
   assign reg_ok  = (reg_off != 2'd3);  // offset 3 is not implemented
   assign addr_ok = ch_ok & reg_ok;

   assign access  = psel & penable;
   assign pready  = access;            // no wait states
   assign pslverr = access & ~addr_ok;

   // remembers that the previous cycle was a SETUP phase
   always_ff @(posedge clk) begin
      if (!reset_b) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel & ~penable;
      end
   end

   // a transfer gives one strobe even if penable were held for longer
   assign strobe = access & setup_q & addr_ok;

   always_comb begin
      cmd = '0;
      for (int i = 0; i < NUM_CH; i++) begin
         cmd[i].wdata = pwdata[7:0];
         if (strobe && (ch_idx == 4'(i))) begin
            cmd[i].tx_load    = pwrite & (reg_sel == REG_DATA);
            cmd[i].rx_pop     = ~pwrite & (reg_sel == REG_DATA);
            cmd[i].status_clr = ~pwrite & (reg_sel == REG_STATUS);
            cmd[i].ctrl_wr    = pwrite & (reg_sel == REG_CTRL);
         end
      end
   end

   // the read mux only needs the address, so it stays valid for the whole ACCESS phase
   assign rd_sel = '{
      ch:        ch_idx,
      reg_sel:   reg_sel,
      rd_active: access & ~pwrite & addr_ok
   };

endmodule

// File: hdl/status_collect.sv
module status_collect #(
   parameter int NUM_CH = 4
) (
   input  logic                            clk,
   input  logic                            reset_b,
   input  uart_pkg::ch_stat_t [NUM_CH-1:0] stat,
   input  uart_pkg::rd_sel_t               rd_sel,
   output logic [31:0]                     prdata,
   output logic                            irq
);
   import uart_pkg::*;

   ch_stat_t sel_stat;
   logic     any_req;

   // pick the addressed channel, out-of-range indices leave it at zero
   always_comb begin
      sel_stat = '0;
      for (int i = 0; i < NUM_CH; i++) begin
         if (rd_sel.ch == 4'(i)) begin
            sel_stat = stat[i];
         end
      end
   end

   // format the read word, bad or idle accesses return zero
   always_comb begin
      prdata = '0;
      if (rd_sel.rd_active) begin
         case (rd_sel.reg_sel)
            REG_STATUS: begin
               prdata[0] = sel_stat.rx_full;
               prdata[1] = sel_stat.tx_busy;
               prdata[2] = sel_stat.overrun;
               prdata[3] = sel_stat.irq_en;
            end
            REG_DATA: prdata[7:0] = sel_stat.rx_data;
            REG_CTRL: prdata[0]   = sel_stat.irq_en;
            default:  prdata      = '0;
         endcase
      end
   end

   always_comb begin
      any_req = 1'b0;
      for (int i = 0; i < NUM_CH; i++) begin
         any_req = any_req | (stat[i].rx_full & stat[i].irq_en);
      end
   end

   // registered so irq is glitch free, one cycle behind the flags
   always_ff @(posedge clk) begin
      if (!reset_b) begin
         irq <= 1'b0;
      end else begin
         irq <= any_req;
      end
   end

endmodule

// File: hdl/uart_bank.sv
module uart_bank #(
   parameter int NUM_CH       = 4,
   parameter int CLKS_PER_BIT = 16
) (
   input  logic              clk,
   input  logic              reset_b,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [7:0]        paddr,
   input  logic [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr,
   output logic              irq,
   input  logic [NUM_CH-1:0] rxd,
   output logic [NUM_CH-1:0] txd
);
   import uart_pkg::*;

   ch_cmd_t  [NUM_CH-1:0] cmd;     // one strobe set per channel
   ch_stat_t [NUM_CH-1:0] stat;
   rd_sel_t               rd_sel;

   apb_decode #(
      .NUM_CH (NUM_CH)
   ) u_dec (
      .clk     (clk),
      .reset_b (reset_b),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .pready  (pready),
      .pslverr (pslverr),
      .cmd     (cmd),
      .rd_sel  (rd_sel)
   );

   for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
      uart_channel #(
         .CLKS_PER_BIT (CLKS_PER_BIT)
      ) u_ch (
         .clk     (clk),
         .reset_b (reset_b),
         .cmd     (cmd[i]),
         .rxd     (rxd[i]),
         .txd     (txd[i]),
         .stat    (stat[i])
      );
   end

   status_collect #(
      .NUM_CH (NUM_CH)
   ) u_col (
      .clk     (clk),
      .reset_b (reset_b),
      .stat    (stat),
      .rd_sel  (rd_sel),
      .prdata  (prdata),
      .irq     (irq)
   );

endmodule

// File: hdl/uart_channel.sv
module uart_channel #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic               clk,
   input  logic               reset_b,
   input  uart_pkg::ch_cmd_t  cmd,
   input  logic               rxd,
   output logic               txd,
   output uart_pkg::ch_stat_t stat
);
   import uart_pkg::*;

   localparam int            CW        = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

   tx_state_e     tx_state_q;
   logic [9:0]    tx_shift_q;
   logic [CW-1:0] tx_cnt_q;
   logic [3:0]    tx_bits_q;

   rx_state_e     rx_state_q;
   logic          rx_s1_q;
   logic          rx_s2_q;
   logic          rx_prev_q;
   logic [CW-1:0] rx_cnt_q;
   logic [3:0]    rx_bits_q;
   logic [7:0]    rx_shift_q;
   logic          rx_start;
   logic          rx_tick;
   logic          rx_data_bit;
   logic          rx_done;
   logic          rx_accept;

   logic          rx_full_q;
   logic          overrun_q;
   logic          irq_en_q;
   logic [7:0]    rx_data_q;

   // transmitter, shifts out start, eight data bits and stop, lsb first
   always_ff @(posedge clk) begin
      if (!reset_b) begin
         tx_state_q <= TX_IDLE;
         tx_shift_q <= '1;  // line idles high
         tx_cnt_q   <= '0;
         tx_bits_q  <= '0;
      end else begin
         case (tx_state_q)
            TX_IDLE: begin
               if (cmd.tx_load) begin  // writes while busy never reach here
                  tx_shift_q <= {1'b1, cmd.wdata, 1'b0};
                  tx_cnt_q   <= BIT_LAST;
                  tx_bits_q  <= '0;
                  tx_state_q <= TX_SHIFT;
               end
            end
            TX_SHIFT: begin
               if (tx_cnt_q == '0) begin
                  tx_cnt_q <= BIT_LAST;
                  if (tx_bits_q == 4'd9) begin  // stop bit has had its full time
                     tx_shift_q <= '1;
                     tx_state_q <= TX_IDLE;
                  end else begin
                     tx_shift_q <= {1'b1, tx_shift_q[9:1]};
                     tx_bits_q  <= tx_bits_q + 4'd1;
                  end
               end else begin
                  tx_cnt_q <= tx_cnt_q - 1'b1;
               end
            end
            default: tx_state_q <= TX_IDLE;
         endcase
      end
   end

   assign txd = tx_shift_q[0];

   // two-flop synchronizer plus one more stage for the edge detect
   always_ff @(posedge clk) begin
      if (!reset_b) begin
         rx_s1_q   <= 1'b1;
         rx_s2_q   <= 1'b1;
         rx_prev_q <= 1'b1;
      end else begin
         rx_s1_q   <= rxd;
         rx_s2_q   <= rx_s1_q;
         rx_prev_q <= rx_s2_q;
      end
   end

   assign rx_start    = rx_prev_q & ~rx_s2_q;                    // falling edge
   assign rx_tick     = (rx_cnt_q == '0);                        // mid-bit sample point
   assign rx_data_bit = (rx_bits_q != 4'd0) && (rx_bits_q != 4'd9);

   // receiver, bit 0 is the start bit and bit 9 the stop bit
   always_ff @(posedge clk) begin
      if (!reset_b) begin
         rx_state_q <= RX_IDLE;
         rx_cnt_q   <= '0;
         rx_bits_q  <= '0;
      end else begin
         case (rx_state_q)
            RX_IDLE: begin
               if (rx_start) begin
                  rx_cnt_q   <= HALF_LAST;  // first sample lands mid start bit
                  rx_bits_q  <= '0;
                  rx_state_q <= RX_SHIFT;
               end
            end
            RX_SHIFT: begin
               if (rx_tick) begin
                  rx_cnt_q  <= BIT_LAST;
                  rx_bits_q <= rx_bits_q + 4'd1;
                  if ((rx_bits_q == 4'd0) && rx_s2_q) begin
                     rx_state_q <= RX_IDLE;  // glitch, not a real start bit
                  end else if (rx_bits_q == 4'd9) begin
                     rx_state_q <= rx_s2_q ? RX_DONE : RX_IDLE;  // bad stop drops the frame
                  end
               end else begin
                  rx_cnt_q <= rx_cnt_q - 1'b1;
               end
            end
            RX_DONE:  rx_state_q <= RX_IDLE;
            default:  rx_state_q <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((rx_state_q == RX_SHIFT) && rx_tick && rx_data_bit) begin
         rx_shift_q <= {rx_s2_q, rx_shift_q[7:1]};
      end
   end

   assign rx_done   = (rx_state_q == RX_DONE);
   assign rx_accept = rx_done & (~rx_full_q | cmd.rx_pop);  // a pop in the same cycle frees the slot

   // holding register flags
   always_ff @(posedge clk) begin
      if (!reset_b) begin
         rx_full_q <= 1'b0;
         overrun_q <= 1'b0;
         irq_en_q  <= 1'b0;
      end else begin
         if (rx_accept) begin
            rx_full_q <= 1'b1;
         end else if (cmd.rx_pop) begin
            rx_full_q <= 1'b0;
         end
         // a new overrun wins over the clear, that read never saw it
         if (rx_done && !rx_accept) begin
            overrun_q <= 1'b1;
         end else if (cmd.status_clr) begin
            overrun_q <= 1'b0;
         end
         if (cmd.ctrl_wr) begin
            irq_en_q <= cmd.wdata[0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_accept) begin
         rx_data_q <= rx_shift_q;  // an overrun byte is discarded here
      end
   end

   assign stat = '{
      tx_busy: (tx_state_q == TX_SHIFT),
      rx_full: rx_full_q,
      overrun: overrun_q,
      irq_en:  irq_en_q,
      rx_data: rx_data_q
   };

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

   // channel field of paddr is four bits wide
   localparam int MAX_CH = 16;

   // register offset within a channel, taken from paddr[3:2]
   typedef enum logic [1:0] {
      REG_STATUS = 2'd0,  // flags, read clears overrun
      REG_DATA   = 2'd1,  // write sends a byte, read pops the held byte
      REG_CTRL   = 2'd2   // bit 0 is the receive interrupt enable
   } reg_sel_e;

   // one-cycle strobes from the APB decoder into one channel
   typedef struct packed {
      logic       tx_load;     // write to DATA
      logic [7:0] wdata;       // low byte of pwdata
      logic       rx_pop;      // read of DATA
      logic       status_clr;  // read of STATUS
      logic       ctrl_wr;     // write to CTRL
   } ch_cmd_t;

   // live state of one channel as seen by the read path
   typedef struct packed {
      logic       tx_busy;
      logic       rx_full;
      logic       overrun;
      logic       irq_en;
      logic [7:0] rx_data;
   } ch_stat_t;

   // which channel and register the current read targets
   typedef struct packed {
      logic [3:0] ch;
      reg_sel_e   reg_sel;
      logic       rd_active;  // good read in its ACCESS phase
   } rd_sel_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_SHIFT,
      RX_DONE
   } rx_state_e;

   typedef enum logic {
      TX_IDLE,
      TX_SHIFT
   } tx_state_e;

endpackage

// File: tb.f
+incdir+bench
hdl/uart_pkg.sv
hdl/apb_decode.sv
hdl/uart_channel.sv
hdl/status_collect.sv
hdl/uart_bank.sv
bench/tb_uart_bank.sv
